/* vlsu_settings.svh */
`ifndef VLSU_SETTINGS_SVH
`define VLSU_SETTINGS_SVH

// Number of vector lanes
// Element i goes to lane i mod VLSU_LANES
`define VLSU_LANES 4

// Element width in bits, one element per memory beat
`define VLSU_ELEN 32

// Byte address width of the memory port
`define VLSU_AW 32

// Width of vector length and element index fields
// 5 bits allow up to 16 elements per instruction
`define VLSU_VLW 5

`endif

/* vlsu_pkg.sv */
`include "vlsu_settings.svh"

package vlsu_pkg;

  // One element word
  typedef logic [`VLSU_ELEN-1:0] elem_t;

  // Byte address and byte stride
  typedef logic [`VLSU_AW-1:0] addr_t;

  // Vector length or element index
  typedef logic [`VLSU_VLW-1:0] vlen_t;

  // Instruction from the sequencer
  typedef struct packed {
    logic  is_store;
    addr_t base;
    // Byte stride, must be a multiple of the element size
    addr_t stride;
    vlen_t vl;
  } ls_req_t;

  // End of instruction report
  typedef struct packed {
    logic valid;
    logic is_store;
    logic bus_err;
  } ls_resp_t;

  // One address beat, one element each
  typedef struct packed {
    addr_t addr;
    vlen_t elem;
    logic  is_store;
    logic  last;
  } addr_beat_t;

  // Completion of one beat
  // rdata is only meaningful for loads
  typedef struct packed {
    elem_t rdata;
    vlen_t elem;
    logic  last;
    logic  err;
  } mem_cpl_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    addr_t                  adr;
    elem_t                  dat;
    logic [`VLSU_ELEN/8-1:0] sel;
  } wb_m2s_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    elem_t dat;
    logic  ack;
    logic  err;
  } wb_s2m_t;

endpackage

/* vlsu_addrgen.sv */
module vlsu_addrgen (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Sequencer request
  input  vlsu_pkg::ls_req_t    req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Earlier instruction still draining
  input  logic                 busy_i,
  output logic                 ack_o,
  output logic                 error_o,
  // Beat stream to the bus master
  output vlsu_pkg::addr_beat_t beat_o,
  output logic                 beat_valid_o,
  input  logic                 beat_ready_i
);

  logic            active_q;
  logic            ack_q;
  logic            error_q;
  logic            is_store_q;
  vlsu_pkg::addr_t addr_q;
  vlsu_pkg::addr_t stride_q;
  vlsu_pkg::vlen_t elem_q;
  vlsu_pkg::vlen_t vl_q;
  logic            accept;
  logic            misaligned;
  logic            beat_fire;

  // Idle, no ack pending and nothing outstanding downstream
  assign req_ready_o = !active_q && !ack_q && !busy_i;
  assign accept      = req_valid_i && req_ready_o;

  // Word alignment of base and stride
  assign misaligned = (|req_i.base[1:0]) || (|req_i.stride[1:0]);

  assign ack_o   = ack_q;
  assign error_o = error_q;

  // Current beat
  assign beat_valid_o    = active_q;
  assign beat_o.addr     = addr_q;
  assign beat_o.elem     = elem_q;
  assign beat_o.is_store = is_store_q;
  assign beat_o.last     = (elem_q == vl_q - 1'b1);
  assign beat_fire       = beat_valid_o && beat_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      ack_q    <= 1'b0;
      error_q  <= 1'b0;
      elem_q   <= '0;
    end else begin
      // Ack and error pulse for one cycle
      ack_q   <= accept;
      error_q <= accept && misaligned;
      if (accept) begin
        // A bad request never starts the beat stream
        active_q <= !misaligned;
        elem_q   <= '0;
      end else if (beat_fire) begin
        if (beat_o.last) begin
          active_q <= 1'b0;
        end else begin
          elem_q <= elem_q + 1'b1;
        end
      end
    end
  end

  // Running address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q     <= req_i.base;
      stride_q   <= req_i.stride;
      vl_q       <= req_i.vl;
      is_store_q <= req_i.is_store;
    end else if (beat_fire) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // Beat held while the bus master stalls
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o));

endmodule

/* vlsu_wb_master.sv */
module vlsu_wb_master (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Beats from the address generator
  input  vlsu_pkg::addr_beat_t beat_i,
  input  logic                 beat_valid_i,
  output logic                 beat_ready_o,
  // Store data from the store unit
  input  vlsu_pkg::elem_t      st_data_i,
  input  logic                 st_data_valid_i,
  output logic                 st_data_ready_o,
  // Wishbone classic
  output vlsu_pkg::wb_m2s_t    wb_o,
  input  vlsu_pkg::wb_s2m_t    wb_i,
  // Completions, steered by direction
  output vlsu_pkg::mem_cpl_t   cpl_o,
  output logic                 ld_cpl_valid_o,
  input  logic                 ld_cpl_ready_i,
  output logic                 st_cpl_valid_o,
  input  logic                 st_cpl_ready_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_bus,
    st_cpl
  } state_e;

  state_e          state_q;
  logic            we_q;
  logic            last_q;
  logic            err_q;
  vlsu_pkg::addr_t adr_q;
  vlsu_pkg::elem_t dat_q;
  vlsu_pkg::elem_t rdata_q;
  vlsu_pkg::vlen_t elem_q;
  logic            beat_fire;
  logic            bus_done;
  logic            cpl_fire;

  // A store beat waits for its data, a load beat goes alone
  assign beat_ready_o    = (state_q == st_idle) && (!beat_i.is_store || st_data_valid_i);
  assign st_data_ready_o = (state_q == st_idle) && beat_valid_i && beat_i.is_store;
  assign beat_fire       = beat_valid_i && beat_ready_o;

  // Slave ends the cycle with ack or err
  assign bus_done = (state_q == st_bus) && (wb_i.ack || wb_i.err);

  // Completion goes to the side that issued the beat
  assign ld_cpl_valid_o = (state_q == st_cpl) && !we_q;
  assign st_cpl_valid_o = (state_q == st_cpl) && we_q;
  assign cpl_fire = (ld_cpl_valid_o && ld_cpl_ready_i) || (st_cpl_valid_o && st_cpl_ready_i);

  always_comb begin
    // cyc and stb rise and fall together
    wb_o.cyc = (state_q == st_bus);
    wb_o.stb = (state_q == st_bus);
    wb_o.we  = we_q;
    wb_o.adr = adr_q;
    wb_o.dat = dat_q;
    // Full element access only
    wb_o.sel = '1;
  end

  always_comb begin
    cpl_o.rdata = rdata_q;
    cpl_o.elem  = elem_q;
    cpl_o.last  = last_q;
    cpl_o.err   = err_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (beat_fire) state_q <= st_bus;
        st_bus:  if (bus_done) state_q <= st_cpl;
        // No new beat until the completion is taken
        st_cpl:  if (cpl_fire) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  // Cycle attributes and returned data
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      adr_q  <= beat_i.addr;
      we_q   <= beat_i.is_store;
      elem_q <= beat_i.elem;
      last_q <= beat_i.last;
      dat_q  <= st_data_i;
    end
    if (bus_done) begin
      rdata_q <= wb_i.dat;
      err_q   <= wb_i.err;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.stb |-> wb_o.cyc);

  // Request held until the slave answers
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_o.stb && !wb_i.ack && !wb_i.err |=>
      wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.dat) && $stable(wb_o.we));

endmodule

/* vldu.sv */
`include "vlsu_settings.svh"

module vldu (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Load completions
  input  vlsu_pkg::mem_cpl_t                   cpl_i,
  input  logic                                 cpl_valid_i,
  output logic                                 cpl_ready_o,
  // Lane write ports
  output logic            [`VLSU_LANES-1:0]    res_req_o,
  output vlsu_pkg::vlen_t [`VLSU_LANES-1:0]    res_idx_o,
  output vlsu_pkg::elem_t [`VLSU_LANES-1:0]    res_data_o,
  input  logic            [`VLSU_LANES-1:0]    res_gnt_i,
  // End of load
  output vlsu_pkg::ls_resp_t                   resp_o,
  output logic                                 busy_o
);

  logic               buf_valid_q;
  vlsu_pkg::mem_cpl_t buf_q;
  logic               err_sticky_q;
  vlsu_pkg::ls_resp_t resp_q;
  logic               cpl_fire;
  logic               gnt;

  // Single entry buffer, refilled once the lane grants
  assign cpl_ready_o = !buf_valid_q;
  assign cpl_fire    = cpl_valid_i && cpl_ready_o;

  always_comb begin
    for (int l = 0; l < `VLSU_LANES; l++) begin
      // Lane from the element index, word index within that lane
      res_req_o[l]  = buf_valid_q && (buf_q.elem % `VLSU_LANES == l);
      res_idx_o[l]  = vlsu_pkg::vlen_t'(buf_q.elem / `VLSU_LANES);
      res_data_o[l] = buf_q.rdata;
    end
  end

  assign gnt = |(res_req_o & res_gnt_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_valid_q  <= 1'b0;
      err_sticky_q <= 1'b0;
      resp_q       <= '0;
    end else begin
      resp_q <= '0;
      if (cpl_fire) begin
        buf_valid_q <= 1'b1;
      end else if (gnt) begin
        buf_valid_q <= 1'b0;
        if (buf_q.last) begin
          // Report, folding in any earlier bus error
          resp_q.valid   <= 1'b1;
          resp_q.bus_err <= err_sticky_q || buf_q.err;
          err_sticky_q   <= 1'b0;
        end else begin
          err_sticky_q <= err_sticky_q || buf_q.err;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cpl_fire) begin
      buf_q <= cpl_i;
    end
  end

  assign resp_o = resp_q;
  assign busy_o = buf_valid_q;

  // Only one lane is written at a time
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(res_req_o));

endmodule

/* vstu.sv */
`include "vlsu_settings.svh"

module vstu (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Vector length of the store, zero when none is active
  input  vlsu_pkg::vlen_t                      vl_i,
  // Operand group from the lanes
  input  vlsu_pkg::elem_t [`VLSU_LANES-1:0]    stu_operand_i,
  input  logic            [`VLSU_LANES-1:0]    stu_operand_valid_i,
  output logic                                 stu_operand_ready_o,
  // Store data in element order
  output vlsu_pkg::elem_t                      st_data_o,
  output logic                                 st_data_valid_o,
  input  logic                                 st_data_ready_i,
  // Store completions
  input  vlsu_pkg::mem_cpl_t                   cpl_i,
  input  logic                                 cpl_valid_i,
  output logic                                 cpl_ready_o,
  output vlsu_pkg::ls_resp_t                   resp_o,
  output logic                                 busy_o
);

  logic                                 active_q;
  logic                                 grp_valid_q;
  logic                                 err_q;
  vlsu_pkg::vlen_t                      vl_q;
  vlsu_pkg::vlen_t                      sent_q;
  vlsu_pkg::vlen_t                      cpl_cnt_q;
  logic [$clog2(`VLSU_LANES)-1:0]       lane_q;
  vlsu_pkg::elem_t [`VLSU_LANES-1:0]    grp_q;
  vlsu_pkg::ls_resp_t                   resp_q;
  logic [`VLSU_LANES-1:0]               need;
  logic                                 take;
  logic                                 data_fire;
  logic                                 grp_end;
  logic                                 cpl_fire;
  logic                                 cpl_done;

  // Lanes past vl in the last group are ignored
  always_comb begin
    for (int l = 0; l < `VLSU_LANES; l++) begin
      need[l] = (32'(sent_q) + l) < 32'(vl_q);
    end
  end

  assign stu_operand_ready_o = active_q && !grp_valid_q && (sent_q < vl_q);
  assign take = stu_operand_ready_o && (&(stu_operand_valid_i | ~need));

  // Serialize the held group lane by lane
  assign st_data_o       = grp_q[lane_q];
  assign st_data_valid_o = grp_valid_q;
  assign data_fire       = st_data_valid_o && st_data_ready_i;
  assign grp_end = (32'(lane_q) == `VLSU_LANES - 1) || (sent_q + 1'b1 == vl_q);

  assign cpl_ready_o = active_q;
  assign cpl_fire    = cpl_valid_i && cpl_ready_o;
  assign cpl_done    = (cpl_cnt_q + 1'b1 == vl_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q    <= 1'b0;
      grp_valid_q <= 1'b0;
      err_q       <= 1'b0;
      vl_q        <= '0;
      sent_q      <= '0;
      cpl_cnt_q   <= '0;
      lane_q      <= '0;
      resp_q      <= '0;
    end else begin
      resp_q <= '0;
      if (!active_q) begin
        // Start once the store is known, not while reporting the last one
        if (vl_i != '0 && !resp_q.valid) begin
          active_q  <= 1'b1;
          vl_q      <= vl_i;
          sent_q    <= '0;
          cpl_cnt_q <= '0;
          err_q     <= 1'b0;
        end
      end else begin
        if (take) begin
          grp_valid_q <= 1'b1;
          lane_q      <= '0;
        end
        if (data_fire) begin
          sent_q <= sent_q + 1'b1;
          lane_q <= lane_q + 1'b1;
          if (grp_end) grp_valid_q <= 1'b0;
        end
        if (cpl_fire) begin
          if (cpl_done) begin
            active_q        <= 1'b0;
            resp_q.valid    <= 1'b1;
            resp_q.is_store <= 1'b1;
            resp_q.bus_err  <= err_q || cpl_i.err;
          end else begin
            cpl_cnt_q <= cpl_cnt_q + 1'b1;
            err_q     <= err_q || cpl_i.err;
          end
        end
      end
    end
  end

  // Group payload
  always_ff @(posedge clk_i) begin
    if (take) begin
      grp_q <= stu_operand_i;
    end
  end

  assign resp_o = resp_q;
  assign busy_o = active_q;

  // Completion count agrees with the last flag from the address generator
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpl_fire |-> (cpl_i.last == cpl_done));

endmodule

/* vlsu.sv */
`include "vlsu_settings.svh"

module vlsu (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Sequencer
  input  vlsu_pkg::ls_req_t                    req_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  output logic                                 addrgen_ack_o,
  output logic                                 addrgen_error_o,
  // Store operands from the lanes
  input  vlsu_pkg::elem_t [`VLSU_LANES-1:0]    stu_operand_i,
  input  logic            [`VLSU_LANES-1:0]    stu_operand_valid_i,
  output logic                                 stu_operand_ready_o,
  // Load results to the lanes
  output logic            [`VLSU_LANES-1:0]    res_req_o,
  output vlsu_pkg::vlen_t [`VLSU_LANES-1:0]    res_idx_o,
  output vlsu_pkg::elem_t [`VLSU_LANES-1:0]    res_data_o,
  input  logic            [`VLSU_LANES-1:0]    res_gnt_i,
  // Memory
  output vlsu_pkg::wb_m2s_t                    wb_o,
  input  vlsu_pkg::wb_s2m_t                    wb_i,
  output vlsu_pkg::ls_resp_t                   resp_o
);

  vlsu_pkg::addr_beat_t beat;
  logic                 beat_valid;
  logic                 beat_ready;
  vlsu_pkg::elem_t      st_data;
  logic                 st_data_valid;
  logic                 st_data_ready;
  vlsu_pkg::mem_cpl_t   cpl;
  logic                 ld_cpl_valid;
  logic                 ld_cpl_ready;
  logic                 st_cpl_valid;
  logic                 st_cpl_ready;
  vlsu_pkg::ls_resp_t   ldu_resp;
  vlsu_pkg::ls_resp_t   stu_resp;
  logic                 ldu_busy;
  logic                 stu_busy;
  logic                 outstanding_q;
  logic                 is_store_q;
  vlsu_pkg::vlen_t      vl_q;
  vlsu_pkg::vlen_t      st_vl;

  // Outstanding from a good ack until the end report
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (addrgen_ack_o && !addrgen_error_o) begin
      outstanding_q <= 1'b1;
    end else if (resp_o.valid) begin
      outstanding_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      is_store_q <= req_i.is_store;
      vl_q       <= req_i.vl;
    end
  end

  // Store unit only sees a length while a store is in flight
  assign st_vl = (outstanding_q && is_store_q) ? vl_q : '0;

  vlsu_addrgen i_addrgen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .busy_i      (outstanding_q || ldu_busy || stu_busy),
    .ack_o       (addrgen_ack_o),
    .error_o     (addrgen_error_o),
    .beat_o      (beat),
    .beat_valid_o(beat_valid),
    .beat_ready_i(beat_ready)
  );

  vlsu_wb_master i_wb_master (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .beat_i         (beat),
    .beat_valid_i   (beat_valid),
    .beat_ready_o   (beat_ready),
    .st_data_i      (st_data),
    .st_data_valid_i(st_data_valid),
    .st_data_ready_o(st_data_ready),
    .wb_o           (wb_o),
    .wb_i           (wb_i),
    .cpl_o          (cpl),
    .ld_cpl_valid_o (ld_cpl_valid),
    .ld_cpl_ready_i (ld_cpl_ready),
    .st_cpl_valid_o (st_cpl_valid),
    .st_cpl_ready_i (st_cpl_ready)
  );

  vldu i_vldu (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cpl_i      (cpl),
    .cpl_valid_i(ld_cpl_valid),
    .cpl_ready_o(ld_cpl_ready),
    .res_req_o  (res_req_o),
    .res_idx_o  (res_idx_o),
    .res_data_o (res_data_o),
    .res_gnt_i  (res_gnt_i),
    .resp_o     (ldu_resp),
    .busy_o     (ldu_busy)
  );

  vstu i_vstu (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .vl_i               (st_vl),
    .stu_operand_i      (stu_operand_i),
    .stu_operand_valid_i(stu_operand_valid_i),
    .stu_operand_ready_o(stu_operand_ready_o),
    .st_data_o          (st_data),
    .st_data_valid_o    (st_data_valid),
    .st_data_ready_i    (st_data_ready),
    .cpl_i              (cpl),
    .cpl_valid_i        (st_cpl_valid),
    .cpl_ready_o        (st_cpl_ready),
    .resp_o             (stu_resp),
    .busy_o             (stu_busy)
  );

  // One instruction at a time, so at most one report is valid
  assign resp_o = ldu_resp | stu_resp;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ldu_resp.valid && stu_resp.valid));

  // A report only ends an accepted, well formed instruction
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_o.valid |-> outstanding_q);

endmodule

/* tb_wb_mem.sv */
module tb_wb_mem (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  vlsu_pkg::wb_m2s_t wb_i,
  output vlsu_pkg::wb_s2m_t wb_o,
  // Expected store stream of the current instruction
  input  vlsu_pkg::addr_t   st_base_i,
  input  vlsu_pkg::addr_t   st_stride_i,
  input  logic              wr_clr_i,
  output int                wr_cnt_o,
  output logic              bad_o
);
  timeunit 1ns;
  timeprecision 1ns;

  // Any access here ends with err
  localparam vlsu_pkg::addr_t poison_addr = 32'h100;

  int   wait_q = 0;
  int   wr_cnt_q = 0;
  logic bad_q = 1'b0;
  logic wr_ack;

  // Read data depends on every address bit above the byte offset
  function automatic vlsu_pkg::elem_t pattern(input vlsu_pkg::addr_t adr);
    return vlsu_pkg::elem_t'(adr >> 2) ^ 32'h5A5A0000;
  endfunction

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_o   <= '0;
      wait_q <= 0;
    end else begin
      wb_o.ack <= 1'b0;
      wb_o.err <= 1'b0;
      // One answer per request, after 0 to 3 wait states
      if (wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err) begin
        if (wait_q == 0) begin
          wb_o.ack <= (wb_i.adr != poison_addr);
          wb_o.err <= (wb_i.adr == poison_addr);
          wb_o.dat <= pattern(wb_i.adr);
          wait_q   <= int'($urandom % 4);
        end else begin
          wait_q <= wait_q - 1;
        end
      end
    end
  end

  // Acked writes of the current store
  assign wr_ack = wb_i.cyc && wb_i.stb && wb_i.we && wb_o.ack;

  always @(posedge clk_i) begin
    if (wr_clr_i) begin
      wr_cnt_q <= 0;
    end else if (wr_ack) begin
      wr_cnt_q <= wr_cnt_q + 1;
    end
  end

  // Write i lands at base + i * stride and carries operand i
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_ack |-> wb_i.adr == st_base_i + vlsu_pkg::addr_t'(wr_cnt_q) * st_stride_i &&
               wb_i.dat == 32'hC0DE0000 + vlsu_pkg::elem_t'(wr_cnt_q))
  else begin
    $display("ERROR store_write: expected adr 0x%08h dat 0x%08h, actual adr 0x%08h dat 0x%08h",
             st_base_i + vlsu_pkg::addr_t'($sampled(wr_cnt_q)) * st_stride_i,
             32'hC0DE0000 + vlsu_pkg::elem_t'($sampled(wr_cnt_q)),
             $sampled(wb_i.adr), $sampled(wb_i.dat));
    bad_q <= 1'b1;
  end

  assign wr_cnt_o = wr_cnt_q;
  assign bad_o    = bad_q;

endmodule

/* tb_vlsu.sv */
`include "vlsu_settings.svh"

module tb_vlsu;
  timeunit 1ns;
  timeprecision 1ns;

  // Six instructions of at most 16 beats, roughly 12 cycles per beat at worst
  // gives about 1200 cycles, so this leaves a wide margin
  localparam int cycle_limit = 4000;

  logic                                 clk;
  logic                                 rst_n = 1'b1;
  vlsu_pkg::ls_req_t                    req;
  logic                                 req_valid;
  logic                                 req_ready;
  logic                                 ag_ack;
  logic                                 ag_err;
  vlsu_pkg::elem_t [`VLSU_LANES-1:0]    operand;
  logic            [`VLSU_LANES-1:0]    operand_valid;
  logic                                 operand_ready;
  logic            [`VLSU_LANES-1:0]    res_req;
  vlsu_pkg::vlen_t [`VLSU_LANES-1:0]    res_idx;
  vlsu_pkg::elem_t [`VLSU_LANES-1:0]    res_data;
  logic            [`VLSU_LANES-1:0]    res_gnt;
  vlsu_pkg::wb_m2s_t                    wb_m2s;
  vlsu_pkg::wb_s2m_t                    wb_s2m;
  vlsu_pkg::ls_resp_t                   resp;
  logic            [31:0]               got_q;
  vlsu_pkg::vlen_t                      grp_q;
  logic            [`VLSU_LANES-1:0]    grp_need;
  logic                                 grp_taken;
  logic                                 bad_pending_q;
  logic                                 mem_bad;
  logic                                 accept;
  int                                   mem_wr_cnt;
  int                                   cycles = 0;
  string                                test_name = "reset";

  assign accept = req_valid && req_ready;

  vlsu dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .req_i              (req),
    .req_valid_i        (req_valid),
    .req_ready_o        (req_ready),
    .addrgen_ack_o      (ag_ack),
    .addrgen_error_o    (ag_err),
    .stu_operand_i      (operand),
    .stu_operand_valid_i(operand_valid),
    .stu_operand_ready_o(operand_ready),
    .res_req_o          (res_req),
    .res_idx_o          (res_idx),
    .res_data_o         (res_data),
    .res_gnt_i          (res_gnt),
    .wb_o               (wb_m2s),
    .wb_i               (wb_s2m),
    .resp_o             (resp)
  );

  tb_wb_mem mem (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .wb_i       (wb_m2s),
    .wb_o       (wb_s2m),
    .st_base_i  (req.base),
    .st_stride_i(req.stride),
    .wr_clr_i   (accept),
    .wr_cnt_o   (mem_wr_cnt),
    .bad_o      (mem_bad)
  );

  // Expected load data at a byte address
  function automatic vlsu_pkg::elem_t mem_pattern(input vlsu_pkg::addr_t adr);
    return vlsu_pkg::elem_t'(adr >> 2) ^ 32'h5A5A0000;
  endfunction

  // Element number from lane and word index
  function automatic int lane_elem(input int lane, input vlsu_pkg::vlen_t idx);
    return int'(idx) * `VLSU_LANES + lane;
  endfunction

  function automatic vlsu_pkg::addr_t elem_addr(input int e);
    return req.base + vlsu_pkg::addr_t'(e) * req.stride;
  endfunction

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
    fail_run($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles in %s", cycles, test_name));
    end
  end

  // Lanes holding an element of the group on offer
  always_comb begin
    for (int l = 0; l < `VLSU_LANES; l++) begin
      grp_need[l] = (int'(grp_q) * `VLSU_LANES + l) < int'(req.vl);
    end
  end

  // Group moves once every lane holding one of its elements is valid
  assign grp_taken = operand_ready && (&(operand_valid | ~grp_need));

  // Lane models: random grants, store operands group by group
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grp_q         <= '0;
      got_q         <= '0;
      res_gnt       <= '0;
      operand_valid <= '0;
      for (int l = 0; l < `VLSU_LANES; l++) operand[l] <= 32'hC0DE0000 + 32'(l);
    end else begin
      res_gnt       <= res_req & `VLSU_LANES'($urandom);
      // Each lane is valid about three cycles in four
      operand_valid <= `VLSU_LANES'($urandom) | `VLSU_LANES'($urandom);
      if (accept) begin
        grp_q <= '0;
        got_q <= '0;
        for (int l = 0; l < `VLSU_LANES; l++) operand[l] <= 32'hC0DE0000 + 32'(l);
      end else begin
        if (grp_taken) begin
          grp_q <= grp_q + 1'b1;
          for (int l = 0; l < `VLSU_LANES; l++) begin
            operand[l] <= 32'hC0DE0000 + 32'((int'(grp_q) + 1) * `VLSU_LANES + l);
          end
        end
        for (int l = 0; l < `VLSU_LANES; l++) begin
          if (res_req[l] && res_gnt[l]) got_q[lane_elem(l, res_idx[l])] <= 1'b1;
        end
      end
    end
  end

  // Set by a rejected request until the next one is accepted
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bad_pending_q <= 1'b0;
    end else if (accept) begin
      bad_pending_q <= 1'b0;
    end else if (ag_ack && ag_err) begin
      bad_pending_q <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (mem_bad) fail_run($sformatf("Memory model saw a wrong store write in %s", test_name));
  end

  for (genvar l = 0; l < `VLSU_LANES; l++) begin : g_lane_check
    // Granted element carries the pattern of its own address
    assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |->
        res_data[l] == mem_pattern(elem_addr(lane_elem(l, res_idx[l]))))
    else report_fail(test_name, mem_pattern(elem_addr(lane_elem(l, $sampled(res_idx[l])))),
                     $sampled(res_data[l]));
    assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |->
        lane_elem(l, res_idx[l]) < int'(req.vl) && !got_q[lane_elem(l, res_idx[l])])
    else fail_run($sformatf("Lane %0d got an element twice or past vl in %s", l, test_name));
  end

  // Wishbone classic rules
  assert property (@(posedge clk) disable iff (!rst_n) wb_m2s.stb |-> wb_m2s.cyc)
  else fail_run("Wishbone stb was high without cyc");
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_m2s.stb && !wb_s2m.ack && !wb_s2m.err |=>
      wb_m2s.stb && $stable(wb_m2s.adr) && $stable(wb_m2s.we) && $stable(wb_m2s.dat))
  else fail_run("Wishbone request changed before ack or err");
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_m2s.stb && (wb_s2m.ack || wb_s2m.err) |=> !wb_m2s.stb)
  else fail_run("Wishbone stb stayed high after ack or err");
  // Every access is element wide
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_m2s.stb |-> wb_m2s.sel == {(`VLSU_ELEN/8){1'b1}})
  else report_fail(test_name, 32'({(`VLSU_ELEN/8){1'b1}}), 32'($sampled(wb_m2s.sel)));

  // Rejected requests
  assert property (@(posedge clk) disable iff (!rst_n) ag_err |-> ag_ack)
  else fail_run("Address error came without its ack");
  assert property (@(posedge clk) disable iff (!rst_n) bad_pending_q |-> !wb_m2s.cyc)
  else fail_run("A bus cycle followed a rejected request");
  assert property (@(posedge clk) disable iff (!rst_n) bad_pending_q |-> !resp.valid)
  else fail_run("An end report followed a rejected request");

  // Issue one instruction and wait for its ack and, if accepted, its report
  task automatic run_instr(input string name, input logic is_store,
                           input vlsu_pkg::addr_t base, input vlsu_pkg::addr_t stride,
                           input vlsu_pkg::vlen_t vl, input logic exp_bus_err);
    logic        bad_align;
    logic [31:0] mask;
    bad_align = (base[1:0] != 2'b00) || (stride[1:0] != 2'b00);
    mask      = (32'd1 << vl) - 32'd1;
    test_name = name;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    req_valid    <= 1'b1;
    req.is_store <= is_store;
    req.base     <= base;
    req.stride   <= stride;
    req.vl       <= vl;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    do @(negedge clk); while (!ag_ack);
    assert (ag_err == bad_align) else report_fail(name, 32'(bad_align), 32'(ag_err));
    if (bad_align) begin
      // Window in which no cycle and no report may appear
      repeat (12) @(posedge clk);
    end else begin
      do @(negedge clk); while (!resp.valid);
      assert (resp.bus_err == exp_bus_err)
      else report_fail(name, 32'(exp_bus_err), 32'(resp.bus_err));
      assert (resp.is_store == is_store) else report_fail(name, 32'(is_store), 32'(resp.is_store));
      if (is_store) begin
        assert (mem_wr_cnt == int'(vl)) else report_fail(name, 32'(vl), 32'(mem_wr_cnt));
      end else begin
        assert (got_q == mask) else report_fail(name, mask, got_q);
      end
    end
  endtask

  initial begin
    void'($urandom(88675));
    rst_n     <= 1'b0;
    req_valid <= 1'b0;
    req       <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (req_ready && !wb_m2s.cyc && !wb_m2s.stb && res_req == '0 && !resp.valid &&
            !ag_ack && !ag_err && !operand_ready)
    else fail_run("Outputs were not at their reset values");
    run_instr("load_unit_stride", 1'b0, 32'h1000, 32'd4, 5'd16, 1'b0);
    run_instr("load_strided", 1'b0, 32'h2004, 32'd12, 5'd7, 1'b0);
    run_instr("misaligned_base", 1'b0, 32'h4002, 32'd4, 5'd4, 1'b0);
    run_instr("store_strided", 1'b1, 32'h3000, 32'd8, 5'd10, 1'b0);
    run_instr("misaligned_stride", 1'b1, 32'h5000, 32'd6, 5'd3, 1'b0);
    // Element 2 hits the poison word
    run_instr("load_poison", 1'b0, 32'h00F0, 32'd8, 5'd5, 1'b1);
    repeat (5) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
vlsu_pkg.sv
vlsu_addrgen.sv
vlsu_wb_master.sv
vldu.sv
vstu.sv
vlsu.sv
tb_wb_mem.sv
tb_vlsu.sv

/* Bender.yml */
package:
  name: vlsu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vlsu_pkg.sv
      - vlsu_addrgen.sv
      - vlsu_wb_master.sv
      - vldu.sv
      - vstu.sv
      - vlsu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_mem.sv
      - tb_vlsu.sv
